//--- project.f
+incdir+src
src/frame_pkg.sv
src/spi_peripheral.sv
src/spi_register.sv
src/graphics.sv
src/top.sv
tb/top_tb.sv

//--- Makefile
# Verilator build and run for the display controller SPI core

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= top_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
PASS_TEXT := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/top_tb.sv
// ##########################################################################
// Display controller SPI core testbench
// Random SPI transactions against a model of responses and raster output
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "frame_cfg.svh"

module top_tb;

    import frame_pkg::*;

    localparam int half_period        = 8;     // System clocks per SPI half-period
    localparam int num_transactions   = 40;
    localparam int frame_cycles       = `FRAME_H_TOTAL * `FRAME_V_TOTAL;
    localparam int transaction_cycles = 4 * 8 * 2 * half_period + 4 * half_period + 56;
    localparam int cycle_limit        = num_transactions * transaction_cycles + 2000;

    logic      clock;
    logic      reset;
    logic      spi_select;
    logic      spi_clock;
    logic      spi_data_in;
    logic      spi_data_out;
    logic      display_clock;
    logic      display_hsync;
    logic      display_vsync;
    luma_t     display_y;
    chroma_t   display_cb;
    chroma_t   display_cr;

    integer    seed;
    int        error_count = 0;
    int        check_count = 0;
    int        cycle_count = 0;
    byte_t     tx_bytes [0:3];

    // Colour model, checks paused while a fill is in flight
    luma_t     exp_y;
    chroma_t   exp_cb;
    chroma_t   exp_cr;
    logic      fill_busy;
    int        hold_until;

    // Raster model, locked to the first vsync edge
    logic      locked;
    logic      prev_vsync;
    int        raster_pos;
    int        pixel_h;
    int        pixel_v;
    logic      in_active;

    top dut_i (
        .clock(clock),
        .reset(reset),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .display_clock(display_clock),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic compare_value(input string what, input int got, input int expected);
        check_count++;
        assert (got == expected) else begin
            error_count++;
            $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clock);
        #2;
    endtask

    // Mode 0, MSB first, reads spi_data_out at each rising edge
    task automatic spi_byte(input byte_t tx, output byte_t rx);
        int i;
        rx = '0;
        for (i = 7; i >= 0; i--) begin
            spi_data_in = tx[i];
            wait_cycles(half_period);
            spi_clock = 1'b1;
            rx[i]     = spi_data_out;
            wait_cycles(half_period);
            spi_clock = 1'b0;
        end
    endtask

    task automatic send_transaction(input int count, output byte_t second_rx);
        int    k;
        byte_t rx;
        second_rx  = '0;
        spi_select = 1'b0;
        wait_cycles(half_period);
        for (k = 0; k < count; k++) begin
            spi_byte(tx_bytes[k], rx);
            if (k == 1) begin
                second_rx = rx;
            end
        end
        wait_cycles(half_period);
        spi_select  = 1'b1;
        spi_data_in = 1'b0;
        wait_cycles(2 * half_period);   // Deselect must reach the FSM
    endtask

    // Cycle counter and timeout
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clocks", cycle_limit);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Display monitor, samples away from the rising edge
    always @(negedge clock) begin
        if (reset) begin
            locked     = 1'b0;
            prev_vsync = 1'b0;
            raster_pos = 0;
        end else begin
            if (locked) begin
                raster_pos = (raster_pos + 1) % frame_cycles;
            end else if (display_vsync && !prev_vsync) begin
                locked     = 1'b1;
                raster_pos = 0;
            end
            if (locked) begin
                pixel_h   = raster_pos % `FRAME_H_TOTAL;
                pixel_v   = raster_pos / `FRAME_H_TOTAL;
                in_active = (pixel_h < `FRAME_H_ACTIVE) && (pixel_v < `FRAME_V_ACTIVE);
                compare_value("hsync", int'(display_hsync), int'(pixel_h < `FRAME_HSYNC_WIDTH));
                compare_value("vsync", int'(display_vsync), int'(pixel_v < `FRAME_VSYNC_WIDTH));
                // Divider and pixel counter both start from reset
                compare_value("display_clock", int'(display_clock), int'(pixel_h % 2 == 0));
                if (!fill_busy && cycle_count >= hold_until) begin
                    compare_value("display_y", int'(display_y), in_active ? int'(exp_y) : 0);
                    compare_value("display_cb", int'(display_cb), in_active ? int'(exp_cb) : 0);
                    compare_value("display_cr", int'(display_cr), in_active ? int'(exp_cr) : 0);
                end
            end
            prev_vsync = display_vsync;
        end
    end

    initial begin
        int    t;
        int    kind;
        byte_t rx;
        seed        = 59;
        reset       = 1'b1;
        spi_select  = 1'b1;
        spi_clock   = 1'b0;
        spi_data_in = 1'b0;
        fill_busy   = 1'b0;
        hold_until  = 0;
        exp_y       = '0;
        exp_cb      = '0;
        exp_cr      = '0;
        repeat (5) @(posedge clock);
        #2 reset = 1'b0;
        wait_cycles(2 * frame_cycles);  // Black frames with syncs only

        for (t = 0; t < num_transactions; t++) begin
            kind        = {$random(seed)} % 4;
            tx_bytes[1] = 8'($random(seed));    // Filler or Y
            tx_bytes[2] = 8'($random(seed));
            tx_bytes[3] = 8'($random(seed));
            case (kind)
                0: begin
                    tx_bytes[0] = `FRAME_OP_CHIP_ID;
                    send_transaction(2, rx);
                    compare_value("chip-ID response", int'(rx), int'(`FRAME_CHIP_ID_VALUE));
                end
                1: begin
                    tx_bytes[0] = `FRAME_OP_FILL_COLOR;
                    fill_busy   = 1'b1;
                    send_transaction(4, rx);
                    compare_value("fill-colour response", int'(rx), 0);
                    exp_y      = tx_bytes[1][3:0];
                    exp_cb     = tx_bytes[2][2:0];
                    exp_cr     = tx_bytes[3][2:0];
                    hold_until = cycle_count + frame_cycles;    // One frame to settle
                    fill_busy  = 1'b0;
                end
                2: begin
                    do begin
                        tx_bytes[0] = 8'($random(seed));
                    end while (tx_bytes[0] == `FRAME_OP_FILL_COLOR ||
                               tx_bytes[0] == `FRAME_OP_CHIP_ID);
                    send_transaction(2, rx);
                    compare_value("unknown opcode response", int'(rx), 0);
                end
                default: begin
                    tx_bytes[0] = `FRAME_OP_FILL_COLOR;
                    send_transaction(1, rx);    // Cut off, colour stays
                end
            endcase
        end

        wait_cycles(2 * frame_cycles);
        assert (locked) else begin
            error_count++;
            $display("The raster never produced a vsync pulse");
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/top.sv
// ##########################################################################
// Display controller SPI core
// SPI command decoder shared by the chip-ID register and graphics
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "frame_cfg.svh"

module top (
    input  logic               clock,
    input  logic               reset,

    input  logic               spi_select,
    input  logic               spi_clock,
    input  logic               spi_data_in,
    output logic               spi_data_out,

    output logic               display_clock,
    output logic               display_hsync,
    output logic               display_vsync,
    output frame_pkg::luma_t   display_y,
    output frame_pkg::chroma_t display_cb,
    output frame_pkg::chroma_t display_cr
);

    import frame_pkg::*;

    // Command bus
    byte_t          opcode;
    logic           opcode_valid;
    byte_t          operand;
    logic           operand_valid;
    operand_count_t operand_count;

    // Chip-ID is the only responder
    byte_t          chip_id_response;
    logic           chip_id_response_valid;

    spi_peripheral spi_peripheral (
        .clock(clock),
        .reset(reset),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .response(chip_id_response),
        .response_valid(chip_id_response_valid)
    );

    spi_register #(
        .register_address(`FRAME_OP_CHIP_ID),
        .register_value(`FRAME_CHIP_ID_VALUE)
    ) chip_id (
        .clock(clock),
        .reset(reset),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .response(chip_id_response),
        .response_valid(chip_id_response_valid)
    );

    graphics graphics (
        .clock(clock),
        .reset(reset),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .display_clock(display_clock),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr)
    );

endmodule

`default_nettype wire

//--- src/graphics.sv
// ##########################################################################
// Graphics
// Fill-colour register written over SPI, raster timing and YCbCr output
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "frame_cfg.svh"

module graphics (
    input  logic                      clock,
    input  logic                      reset,

    input  frame_pkg::byte_t          opcode,
    input  logic                      opcode_valid,
    input  frame_pkg::byte_t          operand,
    input  logic                      operand_valid,
    input  frame_pkg::operand_count_t operand_count,

    output logic                      display_clock,
    output logic                      display_hsync,
    output logic                      display_vsync,
    output frame_pkg::luma_t          display_y,
    output frame_pkg::chroma_t        display_cb,
    output frame_pkg::chroma_t        display_cr
);

    import frame_pkg::*;

    localparam int h_bits = $clog2(`FRAME_H_TOTAL);
    localparam int v_bits = $clog2(`FRAME_V_TOTAL);

    logic              fill_write;
    luma_t             staged_y;
    chroma_t           staged_cb;
    luma_t             fill_y;
    chroma_t           fill_cb;
    chroma_t           fill_cr;

    logic [h_bits-1:0] h_count;
    logic [v_bits-1:0] v_count;
    logic              h_last;
    logic              v_last;
    logic              active;
    logic              clock_toggle;

    assign fill_write = opcode_valid && operand_valid && (opcode == `FRAME_OP_FILL_COLOR);

    // Y and Cb wait here until Cr arrives
    always_ff @(posedge clock) begin
        if (fill_write) begin
            case (operand_count)
                8'd0:    staged_y  <= operand[3:0];
                8'd1:    staged_cb <= operand[2:0];
                default: ;
            endcase
        end
    end

    // All three components change together
    always_ff @(posedge clock) begin
        if (reset) begin
            fill_y  <= '0;
            fill_cb <= '0;
            fill_cr <= '0;
        end else if (fill_write && operand_count == 8'd2) begin
            fill_y  <= staged_y;
            fill_cb <= staged_cb;
            fill_cr <= operand[2:0];
        end
    end

    assign h_last = (h_count == h_bits'(`FRAME_H_TOTAL - 1));
    assign v_last = (v_count == v_bits'(`FRAME_V_TOTAL - 1));

    // Raster position, one pixel per clock
    always_ff @(posedge clock) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            v_count <= v_last ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign active = (int'(h_count) < `FRAME_H_ACTIVE) && (int'(v_count) < `FRAME_V_ACTIVE);

    always_ff @(posedge clock) begin
        if (reset) begin
            clock_toggle  <= 1'b0;
            display_clock <= 1'b0;
            display_hsync <= 1'b0;
            display_vsync <= 1'b0;
            display_y     <= '0;
            display_cb    <= '0;
            display_cr    <= '0;
        end else begin
            clock_toggle  <= !clock_toggle;
            display_clock <= !clock_toggle;     // Reference only
            display_hsync <= int'(h_count) < `FRAME_HSYNC_WIDTH;
            display_vsync <= int'(v_count) < `FRAME_VSYNC_WIDTH;
            display_y     <= active ? fill_y : '0;     // Black outside active area
            display_cb    <= active ? fill_cb : '0;
            display_cr    <= active ? fill_cr : '0;
        end
    end

    counters_in_range: assert property (@(posedge clock) disable iff (reset)
        (int'(h_count) < `FRAME_H_TOTAL) && (int'(v_count) < `FRAME_V_TOTAL));

endmodule

`default_nettype wire

//--- src/spi_register.sv
// ##########################################################################
// SPI read register
// Answers one opcode with a fixed byte on the response path
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module spi_register #(
    parameter frame_pkg::byte_t register_address = 8'h00,
    parameter frame_pkg::byte_t register_value   = 8'h00
) (
    input  logic             clock,
    input  logic             reset,

    input  frame_pkg::byte_t opcode,
    input  logic             opcode_valid,
    output frame_pkg::byte_t response,
    output logic             response_valid
);

    import frame_pkg::*;

    logic address_match;

    assign address_match = opcode_valid && (opcode == register_address);

    always_ff @(posedge clock) begin
        if (reset) begin
            response       <= '0;
            response_valid <= 1'b0;
        end else begin
            response       <= address_match ? register_value : byte_t'(0);
            response_valid <= address_match;    // Follows opcode_valid one clock late
        end
    end

    // Response drops once the transaction is closed
    response_follows_opcode: assert property (@(posedge clock) disable iff (reset)
        !opcode_valid |=> !response_valid);

endmodule

`default_nettype wire

//--- src/spi_peripheral.sv
// ##########################################################################
// SPI peripheral
// Samples the mode 0 SPI pins, decodes opcode and operand bytes and
// shifts out the selected response during the second byte
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module spi_peripheral (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      spi_select,
    input  logic                      spi_clock,
    input  logic                      spi_data_in,
    output logic                      spi_data_out,

    output frame_pkg::byte_t          opcode,
    output logic                      opcode_valid,
    output frame_pkg::byte_t          operand,
    output logic                      operand_valid,
    output frame_pkg::operand_count_t operand_count,

    input  frame_pkg::byte_t          response,
    input  logic                      response_valid
);

    import frame_pkg::*;

    logic [1:0]     select_sync;
    logic [2:0]     clock_sync;     // Third stage for edge detection
    logic [1:0]     data_sync;

    logic           select_active;
    logic           clock_rise;
    logic           clock_fall;
    logic           byte_done;
    byte_t          next_byte;

    spi_state_t     state;
    logic [2:0]     bit_count;
    byte_t          shift_in;
    byte_t          shift_out;
    operand_count_t operand_index;
    logic           load_pending;   // Response load due at next fall

    // Pin synchronisers
    always_ff @(posedge clock) begin
        if (reset) begin
            select_sync <= 2'b11;
            clock_sync  <= 3'b000;
            data_sync   <= 2'b00;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            clock_sync  <= {clock_sync[1:0], spi_clock};
            data_sync   <= {data_sync[0], spi_data_in};
        end
    end

    assign select_active = !select_sync[1];
    assign clock_rise    = clock_sync[1] && !clock_sync[2];
    assign clock_fall    = !clock_sync[1] && clock_sync[2];
    assign next_byte     = {shift_in[6:0], data_sync[1]};  // MSB first
    assign byte_done     = clock_rise && (bit_count == 3'd7);

    // Byte receiver FSM, deselect returns to idle
    always_ff @(posedge clock) begin
        if (reset || !select_active) begin
            state         <= spi_idle;
            bit_count     <= 3'd0;
            shift_in      <= '0;
            operand_index <= '0;
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
        end else begin
            operand_valid <= 1'b0;  // Single cycle pulse
            case (state)
                spi_idle: begin
                    state     <= spi_opcode;
                    bit_count <= 3'd0;
                end
                spi_opcode, spi_operand: begin
                    if (clock_rise) begin
                        shift_in  <= next_byte;
                        bit_count <= bit_count + 3'd1;
                    end
                    if (byte_done) begin
                        state <= spi_operand;
                        if (state == spi_opcode) begin
                            opcode_valid <= 1'b1;   // Held until deselect
                        end else begin
                            operand_valid <= 1'b1;
                            operand_index <= operand_index + 8'd1;
                        end
                    end
                end
                default: state <= spi_idle;
            endcase
        end
    end

    // Completed bytes onto the command bus
    always_ff @(posedge clock) begin
        if (select_active && byte_done) begin
            if (state == spi_opcode) begin
                opcode <= next_byte;
            end else if (state == spi_operand) begin
                operand       <= next_byte;
                operand_count <= operand_index;
            end
        end
    end

    // Response shifter, changes on falling edges only
    always_ff @(posedge clock) begin
        if (reset || !select_active) begin
            load_pending <= 1'b0;
            shift_out    <= '0;
            spi_data_out <= 1'b0;
        end else if (byte_done && state == spi_opcode) begin
            load_pending <= 1'b1;
        end else if (clock_fall && load_pending) begin
            load_pending <= 1'b0;
            if (response_valid) begin
                shift_out    <= response;
                spi_data_out <= response[7];
            end else begin
                shift_out    <= '0;     // Nobody answered
                spi_data_out <= 1'b0;
            end
        end else if (clock_fall) begin
            shift_out    <= {shift_out[6:0], 1'b0};
            spi_data_out <= shift_out[6];
        end
    end

    // Operands only arrive inside an open transaction
    operand_needs_opcode: assert property (@(posedge clock) disable iff (reset)
        operand_valid |-> opcode_valid);

    operand_single_cycle: assert property (@(posedge clock) disable iff (reset)
        operand_valid |=> !operand_valid);

endmodule

`default_nettype wire

//--- src/frame_pkg.sv
// ##########################################################################
// Display controller types
// Shared byte, count and colour types plus the SPI FSM states
// ##########################################################################

`default_nettype none

package frame_pkg;

    // One SPI byte, opcode, operand or response
    typedef logic [7:0] byte_t;

    // Index of an operand within a transaction, first one is 0
    typedef logic [7:0] operand_count_t;

    // Pixel colour components
    typedef logic [3:0] luma_t;
    typedef logic [2:0] chroma_t;

    // SPI byte receiver
    typedef enum logic [1:0] {
        spi_idle,       // Chip select high
        spi_opcode,     // Receiving first byte
        spi_operand     // Receiving later bytes
    } spi_state_t;

endpackage

`default_nettype wire

//--- src/frame_cfg.svh
// ##########################################################################
// Display controller configuration
// Raster geometry, SPI opcodes and the chip-ID answer
// ##########################################################################

`ifndef FRAME_CFG_SVH
`define FRAME_CFG_SVH

// Raster size in pixel clocks and lines
`define FRAME_H_ACTIVE      10
`define FRAME_H_TOTAL       16
`define FRAME_V_ACTIVE      6
`define FRAME_V_TOTAL       8

// Sync pulse lengths
`define FRAME_HSYNC_WIDTH   2   // Pixels
`define FRAME_VSYNC_WIDTH   1   // Lines

// Fill colour, operands are Y, Cb, Cr
`define FRAME_OP_FILL_COLOR 8'h10

// Chip identification
`define FRAME_OP_CHIP_ID    8'hDB
`define FRAME_CHIP_ID_VALUE 8'h81

`endif
